//--- verilog/div_pkg.sv
`default_nettype none

package div_pkg;

    localparam int data_width  = 32;  // fixed by the ISA
    localparam int count_width = 5;   // counts 31 down to 0

    // divide opcodes
    typedef enum logic [1:0] {
        op_divu = 2'd0,  // unsigned quotient
        op_remu = 2'd1,  // unsigned remainder
        op_div  = 2'd2,  // signed quotient
        op_rem  = 2'd3   // signed remainder
    } div_op_e;

    // iterative core states
    typedef enum logic [1:0] {
        st_idle    = 2'd0,  // waiting for load
        st_iterate = 2'd1,  // one quotient bit per clock
        st_correct = 2'd2,  // final remainder restore
        st_finish  = 2'd3   // raw result valid for one cycle
    } core_state_e;

    // request as seen at the unit boundary
    typedef struct packed {
        div_op_e               op;
        logic [data_width-1:0] dividend;
        logic [data_width-1:0] divisor;
    } div_req_t;

    // prepared operands, magnitudes plus fixup flags
    typedef struct packed {
        logic [data_width-1:0] mag_dividend;
        logic [data_width-1:0] mag_divisor;
        logic                  neg_quotient;   // exactly one signed operand negative
        logic                  neg_remainder;  // signed and dividend negative
        logic                  div_zero;
        logic                  want_rem;
    } div_operands_t;

    // unsigned core result
    typedef struct packed {
        logic [data_width-1:0] quotient;
        logic [data_width-1:0] remainder;
    } div_raw_t;

    typedef struct packed {
        logic [data_width-1:0] result;
        logic                  div_zero;
    } div_resp_t;

endpackage

`default_nettype wire

//--- verilog/div_operand_prep.sv
`timescale 1ns/100ps
`default_nettype none

module div_operand_prep (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire div_pkg::div_req_t req,
    input  wire                    done,
    output div_pkg::div_operands_t operands,
    output logic                   load,
    output logic                   busy
);
    import div_pkg::*;

    logic                  accept;      // start taken this cycle
    logic                  is_signed;
    logic                  neg_dividend;
    logic                  neg_divisor;
    div_operands_t         prep;        // combinational version of operands
    logic [data_width-1:0] dividend_abs;
    logic [data_width-1:0] divisor_abs;

    assign accept = start & ~busy;  // starts during a division are dropped

    always_comb begin
        is_signed    = (req.op == op_div) || (req.op == op_rem);
        neg_dividend = is_signed & req.dividend[data_width-1];
        neg_divisor  = is_signed & req.divisor[data_width-1];

        // two's complement magnitude for signed ops only
        dividend_abs = neg_dividend ? (~req.dividend + 1'b1) : req.dividend;
        divisor_abs  = neg_divisor ? (~req.divisor + 1'b1) : req.divisor;
        // most negative value maps onto itself and stays correct unsigned

        prep.mag_dividend  = dividend_abs;
        prep.mag_divisor   = divisor_abs;
        prep.neg_quotient  = neg_dividend ^ neg_divisor;
        prep.neg_remainder = neg_dividend;  // remainder follows dividend sign
        prep.div_zero      = (req.divisor == '0);
        prep.want_rem      = (req.op == op_remu) || (req.op == op_rem);
    end

    // operand payload captured on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            operands <= prep;
        end
    end

    // load strobe and busy level
    always_ff @(posedge clk) begin
        if (rst) begin
            load <= 1'b0;
            busy <= 1'b0;
        end else begin
            load <= accept;  // one cycle strobe for the core
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;  // drops the cycle after done
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/divider_core.sv
`timescale 1ns/100ps
`default_nettype none

// non-restoring unsigned divide, one quotient bit per clock
//
// rem holds one guard bit above the data width so the sign of the
// partial remainder survives the add/subtract step
module divider_core (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         load,
    input  wire div_pkg::div_operands_t operands,
    output div_pkg::div_raw_t           raw,
    output logic                        raw_valid
);
    import div_pkg::*;

    core_state_e                state;
    logic [count_width-1:0]     count_q;    // iterations left minus one
    logic signed [data_width:0] rem_q;      // partial remainder
    logic [data_width-1:0]      quo_q;      // dividend shifts out, quotient in
    logic signed [data_width:0] dvs_q;      // divisor, zero extended
    logic signed [data_width:0] rem_shift;
    logic signed [data_width:0] rem_next;
    logic                       rem_neg;

    assign rem_neg = rem_q[data_width];  // sign of current partial remainder

    // shift rem/quo pair left, then add or subtract divisor
    always_comb begin
        rem_shift = {rem_q[data_width-1:0], quo_q[data_width-1]};
        if (rem_neg) begin
            rem_next = rem_shift + dvs_q;  // negative so add back
        end else begin
            rem_next = rem_shift - dvs_q;
        end
    end

    // control, state and bit counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            count_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (load) begin
                        state   <= st_iterate;
                        count_q <= count_width'(data_width - 1);  // 31
                    end
                end
                st_iterate: begin
                    if (count_q == '0) begin
                        state <= st_correct;  // last bit retired
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                st_correct: begin
                    state <= st_finish;
                end
                st_finish: begin
                    state <= st_idle;  // hand-off cycle done
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (load) begin
                    rem_q <= '0;
                    quo_q <= operands.mag_dividend;           // dividend shifts through quo
                    dvs_q <= {1'b0, operands.mag_divisor};
                end
            end
            st_iterate: begin
                rem_q <= rem_next;
                // new quotient bit is inverse of result sign
                quo_q <= {quo_q[data_width-2:0], ~rem_next[data_width]};
            end
            st_correct: begin
                if (rem_neg) begin
                    rem_q <= rem_q + dvs_q;  // restore once at the end
                end
            end
            default: begin
                // hold, raw stays stable until next load
            end
        endcase
    end

    // zero divisor falls out naturally
    // every step subtracts 0 so quotient is all ones, remainder is dividend

    assign raw.quotient  = quo_q;
    assign raw.remainder = rem_q[data_width-1:0];  // guard bit is 0 after correct
    assign raw_valid     = (state == st_finish);     // single cycle

endmodule

`default_nettype wire

//--- verilog/div_result_fix.sv
`timescale 1ns/100ps
`default_nettype none

module div_result_fix (
    input  wire                         clk,
    input  wire                         rst,
    input  wire div_pkg::div_operands_t operands,
    input  wire div_pkg::div_raw_t      raw,
    input  wire                         raw_valid,
    output div_pkg::div_resp_t          resp,
    output logic                        done
);
    import div_pkg::*;

    logic [data_width-1:0] quo_fix;
    logic [data_width-1:0] rem_fix;
    logic [data_width-1:0] sel_result;

    always_comb begin
        // sign restore
        quo_fix = operands.neg_quotient ? (~raw.quotient + 1'b1) : raw.quotient;
        rem_fix = operands.neg_remainder ? (~raw.remainder + 1'b1) : raw.remainder;

        // div by zero, quotient all ones even for signed ops
        if (operands.div_zero) begin
            quo_fix = '1;
        end
        // remainder is already the signed dividend here
        // core gives mag_dividend and neg_remainder puts the sign back

        // min_int / -1 wraps to 0x80000000, rem 0, nothing extra

        sel_result = operands.want_rem ? rem_fix : quo_fix;
    end

    // response payload, held until next done
    always_ff @(posedge clk) begin
        if (raw_valid) begin
            resp.result   <= sel_result;
            resp.div_zero <= operands.div_zero;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= raw_valid;  // one cycle pulse with resp
        end
    end

endmodule

`default_nettype wire

//--- verilog/div_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

// 32-bit divide unit, divu/remu/div/rem, fixed 36 cycle latency
module div_unit_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire div_pkg::div_req_t req,
    output logic                   busy,
    output logic                   done,
    output div_pkg::div_resp_t     resp
);
    import div_pkg::*;

    div_operands_t operands;   // registered magnitudes and flags
    logic          load;       // core load strobe
    div_raw_t      raw;        // unsigned quotient/remainder
    logic          raw_valid;

    // input side
    div_operand_prep u_prep (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .req      (req),
        .done     (done),      // releases busy
        .operands (operands),
        .load     (load),
        .busy     (busy)
    );

    // iterative core
    divider_core u_core (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .operands  (operands),
        .raw       (raw),
        .raw_valid (raw_valid)
    );

    // output side
    div_result_fix u_fix (
        .clk       (clk),
        .rst       (rst),
        .operands  (operands),  // flags stay stable for the whole division
        .raw       (raw),
        .raw_valid (raw_valid),
        .resp      (resp),
        .done      (done)
    );

endmodule

`default_nettype wire

//--- verification/div_tb.sv
`timescale 1ns/100ps
`default_nettype none

module div_tb;
    import div_pkg::*;

    localparam int clk_period     = 40;
    localparam int reset_cycles   = 8;
    localparam int latency        = 36;   // posedges from start drive to done
    localparam int num_ops        = 80;   // includes the idle stretch after the busy test
    localparam int timeout_cycles = num_ops * 40 + reset_cycles;

    logic      clk;
    logic      rst;
    logic      start;
    div_req_t  req;
    logic      busy;
    logic      done;
    div_resp_t resp;

    logic [31:0] exp_result_q[$];  // expected results in issue order
    logic        exp_zero_q[$];
    time         start_time_q[$];  // posedge that drove start
    logic [31:0] a;
    logic [31:0] b;

    div_unit_top uut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .resp  (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // expected result straight from the ISA divide rules
    function automatic div_resp_t ref_div(input div_op_e op, input logic [31:0] x,
                                          input logic [31:0] y);
        div_resp_t         r;
        logic signed [31:0] sx;
        logic signed [31:0] sy;
        logic               ovf;
        sx = x;
        sy = y;
        ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff);  // min / -1
        r.div_zero = (y == 32'h0);
        case (op)
            op_divu: r.result = (y == 32'h0) ? 32'hffff_ffff : x / y;
            op_remu: r.result = (y == 32'h0) ? x : x % y;
            op_div: begin
                if (y == 32'h0)  r.result = 32'hffff_ffff;
                else if (ovf)    r.result = 32'h8000_0000;
                else             r.result = sx / sy;  // truncates toward zero
            end
            default: begin
                if (y == 32'h0)  r.result = x;
                else if (ovf)    r.result = 32'h0;
                else             r.result = sx % sy;  // sign of dividend
            end
        endcase
        return r;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
        end
    endtask

    // start pulse plus request with the expected value queued for the checker
    task automatic issue(input div_op_e op, input logic [31:0] x, input logic [31:0] y);
        div_resp_t exp;
        exp = ref_div(op, x, y);
        @(posedge clk);
        start        <= 1'b1;
        req.op       <= op;
        req.dividend <= x;
        req.divisor  <= y;
        exp_result_q.push_back(exp.result);
        exp_zero_q.push_back(exp.div_zero);
        start_time_q.push_back($time);
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("busy", busy, 32'h1);  // set by the accepting edge
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (exp_result_q.size() != 0 || busy);
    endtask

    task automatic run_op(input div_op_e op, input logic [31:0] x, input logic [31:0] y);
        issue(op, x, y);
        wait_idle();
    endtask

    // compares every done against the oldest outstanding request
    initial begin
        logic [31:0] exp_res;
        logic        exp_zero;
        time         t0;
        forever begin
            @(negedge clk);
            if (!rst && done) begin
                if (exp_result_q.size() == 0) begin
                    report_failure("done pulsed with no division in flight");
                end
                exp_res  = exp_result_q.pop_front();
                exp_zero = exp_zero_q.pop_front();
                t0       = start_time_q.pop_front();
                check_value("resp.result", resp.result, exp_res);
                check_value("resp.div_zero", {31'h0, resp.div_zero}, {31'h0, exp_zero});
                check_value("latency", 32'(($time - t0 - clk_period / 2) / clk_period),
                            32'(latency));
                check_value("busy", busy, 32'h1);  // still high during done
                @(negedge clk);
                check_value("done", done, 32'h0);  // single cycle pulse
                check_value("busy", busy, 32'h0);  // drops right after done
            end
        end
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        report_failure("timeout: the test sequence did not finish in the allowed time");
    end

    initial begin
        void'($urandom(16));
        rst    = 1'b1;
        start  = 1'b0;
        req    = '0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy", busy, 32'h0);
        check_value("done", done, 32'h0);

        // unsigned with a mix of small and full range divisors
        for (int i = 0; i < 40; i++) begin
            a = $urandom;
            b = (i % 3 == 0) ? ($urandom % 1000 + 1) : $urandom;
            if (i % 4 == 1) a = a | 32'h8000_0000;  // top bit set
            if (i % 5 == 2) b = b | 32'h8000_0000;
            if (b == 32'h0) b = 32'h1;
            run_op((i % 2 == 1) ? op_remu : op_divu, a, b);
        end

        // signed over all four sign combinations
        for (int s = 0; s < 4; s++) begin
            a = s[1] ? 32'hffff_fff9 : 32'd7;  // +-7 / +-2
            b = s[0] ? 32'hffff_fffe : 32'd2;
            run_op(op_div, a, b);
            run_op(op_rem, a, b);
            for (int k = 0; k < 2; k++) begin
                a = $urandom;
                b = (k == 0) ? ($urandom % 4096 + 1) : $urandom;
                a[31] = s[1];
                b[31] = s[0];
                if (b == 32'h0) b = 32'h1;
                run_op(op_div, a, b);
                run_op(op_rem, a, b);
            end
        end

        // divide by zero on every opcode
        for (int i = 0; i < 4; i++) begin
            a = $urandom;
            a[31] = i[1];  // negative dividend for the signed pair
            run_op(div_op_e'(i[1:0]), a, 32'h0);
        end

        // corner cases
        run_op(op_div, 32'h8000_0000, 32'hffff_ffff);
        run_op(op_rem, 32'h8000_0000, 32'hffff_ffff);
        run_op(op_divu, 32'h0, 32'd12345);
        run_op(op_rem, 32'h0, 32'hffff_fff9);
        run_op(op_div, 32'hdead_beef, 32'h1);
        run_op(op_remu, 32'hdead_beef, 32'h1);
        run_op(op_divu, 32'h9abc_def0, 32'h9abc_def0);
        run_op(op_div, 32'hffff_ff85, 32'hffff_ff85);

        // second start during a division must be dropped
        issue(op_divu, 32'd1000000, 32'd7);
        repeat (6) @(posedge clk);
        start        <= 1'b1;
        req.op       <= op_rem;
        req.dividend <= 32'hffff_0000;
        req.divisor  <= 32'd3;
        @(posedge clk);
        start <= 1'b0;
        wait_idle();
        repeat (80) @(negedge clk);  // room for a stray second done

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/divider_core.sv
verilog/div_result_fix.sv
verilog/div_unit_top.sv
verification/div_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f verilog.f \
    --top-module div_tb \
    -o div_sim

if ! output=$(./obj_dir/div_sim 2>&1); then
    echo "$output"
    echo "simulation exited with an error"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
